// File: taint_pkg.sv
package taint_pkg;

    // datapath widths
    localparam int WORD_WIDTH = 16;
    localparam int ADDR_WIDTH = 4;

    // low bits of b used as shift amount
    localparam int SHIFT_BITS = 4;

    // one extra bit so a full memory can be counted
    localparam int COUNT_WIDTH = ADDR_WIDTH + 1;

    // value words and taint masks share one type
    typedef logic [WORD_WIDTH-1:0] word_t;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    typedef logic [COUNT_WIDTH-1:0] count_t;

    // fully poisoned mask
    localparam word_t TAINT_ALL = '1;

    // alu operations
    typedef enum logic [3:0] {
        // bitwise and arithmetic
        op_and     = 4'd0,
        op_or      = 4'd1,
        op_xor     = 4'd2,
        op_add     = 4'd3,
        op_mul     = 4'd4,
        // compare and shifts
        op_eq      = 4'd5,
        op_shl     = 4'd6,
        op_shr     = 4'd7,
        // reductions of operand a only
        op_red_or  = 4'd8,
        op_red_and = 4'd9,
        op_red_xor = 4'd10
    } alu_op_e;

endpackage

// File: taint_bus_if.sv
interface taint_bus_if;

    // write command held by the stage register
    logic              valid;
    taint_pkg::word_t  data;
    taint_pkg::word_t  data_taint;
    taint_pkg::addr_t  addr;
    logic              addr_taint;
    logic              en_taint;

    modport src (
        output valid,
        output data,
        output data_taint,
        output addr,
        output addr_taint,
        output en_taint
    );

    modport dst (
        input valid,
        input data,
        input data_taint,
        input addr,
        input addr_taint,
        input en_taint
    );

endinterface

// File: taint_alu.sv
module taint_alu (
    input  taint_pkg::alu_op_e op,
    input  taint_pkg::word_t   a,
    input  taint_pkg::word_t   b,
    input  taint_pkg::word_t   a_taint,
    input  taint_pkg::word_t   b_taint,
    output taint_pkg::word_t   result,
    output taint_pkg::word_t   result_taint
);

    logic [taint_pkg::SHIFT_BITS-1:0] shamt;
    logic                             a_tainted;
    logic                             b_tainted;
    taint_pkg::word_t                 eq_care;
    logic                             eq_taint;
    logic                             red_or_taint;
    logic                             red_and_taint;

    assign shamt = b[taint_pkg::SHIFT_BITS-1:0];

    assign a_tainted = |a_taint;
    assign b_tainted = |b_taint;

    // bits that neither operand has tainted
    assign eq_care = ~(a_taint | b_taint);

    // untainted bits already differ -> result is fixed
    assign eq_taint = ((a & eq_care) == (b & eq_care)) && (a_tainted || b_tainted);

    // an untainted 1 pins the or reduction
    assign red_or_taint = !(|(~a_taint & a)) && a_tainted;

    // an untainted 0 pins the and reduction
    assign red_and_taint = (&(a_taint | a)) && a_tainted;

    // functional result
    always_comb begin
        result = '0;
        case (op)
            taint_pkg::op_and: begin
                result = a & b;
            end
            taint_pkg::op_or: begin
                result = a | b;
            end
            taint_pkg::op_xor: begin
                result = a ^ b;
            end
            taint_pkg::op_add: begin
                result = a + b;
            end
            taint_pkg::op_mul: begin
                result = a * b;
            end
            taint_pkg::op_eq: begin
                result[0] = (a == b);
            end
            taint_pkg::op_shl: begin
                result = a << shamt;
            end
            taint_pkg::op_shr: begin
                result = a >> shamt;
            end
            taint_pkg::op_red_or: begin
                result[0] = |a;
            end
            taint_pkg::op_red_and: begin
                result[0] = &a;
            end
            taint_pkg::op_red_xor: begin
                result[0] = ^a;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // taint propagation
    always_comb begin
        result_taint = '0;
        case (op)
            taint_pkg::op_and: begin
                result_taint = (a_taint & b) | (b_taint & a) | (a_taint & b_taint);
            end
            taint_pkg::op_or: begin
                result_taint = (a_taint & ~b) | (b_taint & ~a) | (a_taint & b_taint);
            end
            taint_pkg::op_xor, taint_pkg::op_add: begin
                result_taint = a_taint | b_taint;
            end
            taint_pkg::op_mul: begin
                result_taint = (a_tainted || b_tainted) ? taint_pkg::TAINT_ALL : '0;
            end
            taint_pkg::op_eq: begin
                result_taint[0] = eq_taint;
            end
            // a tainted amount can move any bit anywhere
            taint_pkg::op_shl: begin
                result_taint = b_tainted ? taint_pkg::TAINT_ALL : a_taint << shamt;
            end
            taint_pkg::op_shr: begin
                result_taint = b_tainted ? taint_pkg::TAINT_ALL : a_taint >> shamt;
            end
            taint_pkg::op_red_or: begin
                result_taint[0] = red_or_taint;
            end
            taint_pkg::op_red_and: begin
                result_taint[0] = red_and_taint;
            end
            taint_pkg::op_red_xor: begin
                result_taint[0] = a_tainted;
            end
            default: begin
                result_taint = '0;
            end
        endcase
    end

endmodule

// File: taint_stage.sv
module taint_stage (
    input  logic             pos_clk,
    input  logic             pos_arst,
    input  logic             en,
    input  logic             en_taint,
    input  taint_pkg::word_t result,
    input  taint_pkg::word_t result_taint,
    input  taint_pkg::addr_t addr,
    input  logic             addr_taint,
    taint_bus_if.src         bus
);

    logic             valid_q;
    logic             en_taint_q;
    taint_pkg::word_t data_q;
    taint_pkg::word_t taint_q;
    taint_pkg::addr_t addr_q;
    logic             addr_taint_q;
    taint_pkg::word_t en_flip;

    // bits that would differ had the enable gone the other way
    assign en_flip = en_taint ? (result ^ data_q) : '0;

    // valid and the enable taint follow their inputs every edge
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            valid_q    <= 1'b0;
            en_taint_q <= 1'b0;
        end else begin
            valid_q    <= en;
            en_taint_q <= en_taint;
        end
    end

    // payload, loaded only on enable
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            data_q       <= '0;
            addr_q       <= '0;
            addr_taint_q <= 1'b0;
        end else if (en) begin
            data_q       <= result;
            addr_q       <= addr;
            addr_taint_q <= addr_taint;
        end
    end

    // enabled-register taint rule
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            taint_q <= '0;
        end else begin
            taint_q <= (en ? result_taint : taint_q) | en_flip;
        end
    end

    assign bus.valid      = valid_q;
    assign bus.data       = data_q;
    assign bus.data_taint = taint_q;
    assign bus.addr       = addr_q;
    assign bus.addr_taint = addr_taint_q;
    assign bus.en_taint   = en_taint_q;

endmodule

// File: taint_mem.sv
module taint_mem #(
    parameter int DEPTH = 16
) (
    input  logic              pos_clk,
    input  logic              pos_arst,
    taint_bus_if.dst          bus,
    input  logic              rd_en,
    input  taint_pkg::addr_t  rd_addr,
    input  logic              rd_addr_taint,
    output taint_pkg::word_t  rd_data,
    output taint_pkg::word_t  rd_taint,
    output taint_pkg::count_t taint_count
);

    taint_pkg::word_t  mem_data  [DEPTH];
    taint_pkg::word_t  mem_taint [DEPTH];
    logic              wr_hit;
    logic              rd_hit;
    taint_pkg::word_t  wr_taint;
    taint_pkg::word_t  rd_poison;
    taint_pkg::count_t tainted_words;

    // out-of-range addresses are ignored
    assign wr_hit = bus.valid && (bus.addr < DEPTH);
    assign rd_hit = rd_en && (rd_addr < DEPTH);

    // tainted address or enable may hit any word, so poison it all
    assign wr_taint = bus.data_taint |
                      ((bus.addr_taint || bus.en_taint) ? taint_pkg::TAINT_ALL : '0);

    assign rd_poison = rd_addr_taint ? taint_pkg::TAINT_ALL : '0;

    // write port
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_data[i]  <= '0;
                mem_taint[i] <= '0;
            end
        end else if (wr_hit) begin
            mem_data[bus.addr]  <= bus.data;
            mem_taint[bus.addr] <= wr_taint;
        end
    end

    // synchronous read port
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            rd_data  <= '0;
            rd_taint <= '0;
        end else if (rd_hit) begin
            rd_data  <= mem_data[rd_addr];
            rd_taint <= mem_taint[rd_addr] | rd_poison;
        end else begin
            rd_data  <= '0;
            rd_taint <= '0;
        end
    end

    // words carrying any taint
    always_comb begin
        tainted_words = '0;
        for (int i = 0; i < DEPTH; i++) begin
            tainted_words = tainted_words + taint_pkg::count_t'(|mem_taint[i]);
        end
    end

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            taint_count <= '0;
        end else begin
            taint_count <= tainted_words;
        end
    end

endmodule

// File: taint_core.sv
module taint_core #(
    parameter int DEPTH = 16
) (
    input  logic               pos_clk,
    input  logic               pos_arst,
    input  logic               in_valid,
    input  logic               in_valid_taint,
    input  taint_pkg::alu_op_e op,
    input  taint_pkg::word_t   a,
    input  taint_pkg::word_t   b,
    input  taint_pkg::word_t   a_taint,
    input  taint_pkg::word_t   b_taint,
    input  taint_pkg::addr_t   wr_addr,
    input  logic               wr_addr_taint,
    input  logic               rd_en,
    input  taint_pkg::addr_t   rd_addr,
    input  logic               rd_addr_taint,
    output taint_pkg::word_t   rd_data,
    output taint_pkg::word_t   rd_taint,
    output taint_pkg::count_t  taint_count
);

    taint_pkg::word_t alu_result;
    taint_pkg::word_t alu_result_taint;

    // stage to memory write command
    taint_bus_if wr_bus ();

    taint_alu alu0 (
        .op           (op),
        .a            (a),
        .b            (b),
        .a_taint      (a_taint),
        .b_taint      (b_taint),
        .result       (alu_result),
        .result_taint (alu_result_taint)
    );

    taint_stage stage0 (
        .pos_clk      (pos_clk),
        .pos_arst     (pos_arst),
        .en           (in_valid),
        .en_taint     (in_valid_taint),
        .result       (alu_result),
        .result_taint (alu_result_taint),
        .addr         (wr_addr),
        .addr_taint   (wr_addr_taint),
        .bus          (wr_bus.src)
    );

    taint_mem #(
        .DEPTH (DEPTH)
    ) mem0 (
        .pos_clk       (pos_clk),
        .pos_arst      (pos_arst),
        .bus           (wr_bus.dst),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_addr_taint (rd_addr_taint),
        .rd_data       (rd_data),
        .rd_taint      (rd_taint),
        .taint_count   (taint_count)
    );

endmodule

// File: tb_clock.sv
module tb_clock #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic pos_clk,
    output logic pos_arst
);

    initial begin
        pos_clk = 1'b0;
        forever #(PERIOD / 2) pos_clk = ~pos_clk;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        pos_arst = 1'b1;
        repeat (RESET_CYCLES) @(posedge pos_clk);
        #1 pos_arst = 1'b0;
    end

endmodule

// File: taint_tb.sv
module taint_tb;

    localparam int DEPTH        = 16;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    // reset, then each test in order
    localparam int TEST_CYCLES  = RESET_CYCLES + 18 + 14 + 40 + 10 + 10 + 10;

    logic               pos_clk;
    logic               pos_arst;
    logic               in_valid;
    logic               in_valid_taint;
    taint_pkg::alu_op_e op;
    taint_pkg::word_t   a;
    taint_pkg::word_t   b;
    taint_pkg::word_t   a_taint;
    taint_pkg::word_t   b_taint;
    taint_pkg::addr_t   wr_addr;
    logic               wr_addr_taint;
    logic               rd_en;
    taint_pkg::addr_t   rd_addr;
    logic               rd_addr_taint;
    taint_pkg::word_t   rd_data;
    taint_pkg::word_t   rd_taint;
    taint_pkg::count_t  taint_count;

    // reference model state
    logic               m_valid;
    logic               m_en_taint;
    logic               m_addr_taint;
    taint_pkg::word_t   m_data;
    taint_pkg::word_t   m_taint;
    taint_pkg::addr_t   m_addr;
    taint_pkg::word_t   m_mem_data [DEPTH];
    taint_pkg::word_t   m_mem_taint [DEPTH];
    taint_pkg::word_t   m_rd_data;
    taint_pkg::word_t   m_rd_taint;
    taint_pkg::count_t  m_count;
    logic [31:0]        lfsr;

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clk0 (.pos_clk, .pos_arst);

    taint_core #(.DEPTH(DEPTH)) dut0 (.*);

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output taint_pkg::word_t w);
        for (int i = 0; i < taint_pkg::WORD_WIDTH; i++) begin
            lfsr = lfsr_step(lfsr);
            w[i] = lfsr[0];
        end
    endtask

    function automatic taint_pkg::word_t model_result(input taint_pkg::alu_op_e o,
                                                      input taint_pkg::word_t x, y);
        case (o)
            taint_pkg::op_and:     model_result = x & y;
            taint_pkg::op_or:      model_result = x | y;
            taint_pkg::op_xor:     model_result = x ^ y;
            taint_pkg::op_add:     model_result = x + y;
            taint_pkg::op_mul:     model_result = x * y;
            taint_pkg::op_eq:      model_result = taint_pkg::word_t'(x == y);
            taint_pkg::op_shl:     model_result = x << y[taint_pkg::SHIFT_BITS-1:0];
            taint_pkg::op_shr:     model_result = x >> y[taint_pkg::SHIFT_BITS-1:0];
            taint_pkg::op_red_or:  model_result = taint_pkg::word_t'(x != 0);
            taint_pkg::op_red_and: model_result = taint_pkg::word_t'(x == '1);
            taint_pkg::op_red_xor: model_result = taint_pkg::word_t'(^x);
            default:               model_result = '0;
        endcase
    endfunction

    function automatic taint_pkg::word_t model_taint(input taint_pkg::alu_op_e o,
                                                     input taint_pkg::word_t x, y, xt, yt);
        taint_pkg::word_t                 any;
        logic [taint_pkg::SHIFT_BITS-1:0] sh;
        any = xt | yt;
        sh = y[taint_pkg::SHIFT_BITS-1:0];
        case (o)
            taint_pkg::op_and:     model_taint = (xt & y) | (yt & x) | (xt & yt);
            taint_pkg::op_or:      model_taint = (xt & ~y) | (yt & ~x) | (xt & yt);
            taint_pkg::op_xor:     model_taint = any;
            taint_pkg::op_add:     model_taint = any;
            taint_pkg::op_mul:     model_taint = (any != 0) ? '1 : '0;
            taint_pkg::op_eq:
                model_taint = taint_pkg::word_t'((((x ^ y) & ~any) == 0) && (any != 0));
            taint_pkg::op_shl:     model_taint = (yt != 0) ? '1 : xt << sh;
            taint_pkg::op_shr:     model_taint = (yt != 0) ? '1 : xt >> sh;
            taint_pkg::op_red_or:
                model_taint = taint_pkg::word_t'(((x & ~xt) == 0) && (xt != 0));
            taint_pkg::op_red_and:
                model_taint = taint_pkg::word_t'(((x | xt) == '1) && (xt != 0));
            taint_pkg::op_red_xor: model_taint = taint_pkg::word_t'(xt != 0);
            default:               model_taint = '0;
        endcase
    endfunction

    function automatic taint_pkg::count_t count_tainted();
        count_tainted = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (m_mem_taint[i] != 0) begin
                count_tainted = count_tainted + 1'b1;
            end
        end
    endfunction

    // one rising edge of the model using the inputs sampled at that edge
    task automatic model_tick();
        taint_pkg::word_t r;
        taint_pkg::word_t rt;
        r = model_result(op, a, b);
        rt = model_taint(op, a, b, a_taint, b_taint);
        m_count = count_tainted();
        if (rd_en && rd_addr < DEPTH) begin
            m_rd_data = m_mem_data[rd_addr];
            m_rd_taint = m_mem_taint[rd_addr] | {taint_pkg::WORD_WIDTH{rd_addr_taint}};
        end else begin
            m_rd_data = '0;
            m_rd_taint = '0;
        end
        if (m_valid && m_addr < DEPTH) begin
            m_mem_data[m_addr] = m_data;
            m_mem_taint[m_addr] = m_taint | {taint_pkg::WORD_WIDTH{m_addr_taint || m_en_taint}};
        end
        m_taint = (in_valid ? rt : m_taint) | (in_valid_taint ? (r ^ m_data) : '0);
        if (in_valid) begin
            m_data = r;
            m_addr = wr_addr;
            m_addr_taint = wr_addr_taint;
        end
        m_valid = in_valid;
        m_en_taint = in_valid_taint;
    endtask

    task automatic tick();
        @(posedge pos_clk);
        #1;
        model_tick();
    endtask

    task automatic check_word(input string name, input taint_pkg::word_t exp,
                              input taint_pkg::word_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input taint_pkg::count_t exp,
                               input taint_pkg::count_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic set_op(input taint_pkg::alu_op_e o, input taint_pkg::word_t x, y, xt, yt,
                          input taint_pkg::addr_t addr, input logic addr_poison);
        op = o;
        a = x;
        b = y;
        a_taint = xt;
        b_taint = yt;
        wr_addr = addr;
        wr_addr_taint = addr_poison;
        in_valid = 1'b1;
        in_valid_taint = 1'b0;
    endtask

    // capture edge then the edge that writes memory
    task automatic write_op(input taint_pkg::alu_op_e o, input taint_pkg::word_t x, y, xt, yt,
                            input taint_pkg::addr_t addr, input logic addr_poison);
        set_op(o, x, y, xt, yt, addr, addr_poison);
        tick();
        in_valid = 1'b0;
        tick();
    endtask

    task automatic read_back(input string name, input taint_pkg::addr_t addr,
                             input logic poison);
        rd_en = 1'b1;
        rd_addr = addr;
        rd_addr_taint = poison;
        tick();
        rd_en = 1'b0;
        rd_addr_taint = 1'b0;
        check_word({name, " data"}, m_rd_data, rd_data);
        check_word({name, " taint"}, m_rd_taint, rd_taint);
        check_count({name, " count"}, m_count, taint_count);
    endtask

    task automatic op_case(input string name, input taint_pkg::alu_op_e o,
                           input taint_pkg::word_t x, y, xt, yt);
        write_op(o, x, y, xt, yt, 4'd10, 1'b0);
        read_back(name, 4'd10, 1'b0);
    endtask

    task automatic test_reset();
        check_count("reset count", '0, taint_count);
        for (int i = 0; i < DEPTH; i++) begin
            rd_en = 1'b1;
            rd_addr = taint_pkg::addr_t'(i);
            tick();
            check_word("reset data", '0, rd_data);
            check_word("reset taint", '0, rd_taint);
        end
        rd_en = 1'b0;
    endtask

    // back to back with two operations in flight
    task automatic test_logic_arith();
        taint_pkg::alu_op_e ops [5];
        taint_pkg::word_t   x, y, xt, yt, m;
        ops = '{taint_pkg::op_and, taint_pkg::op_or, taint_pkg::op_xor,
                taint_pkg::op_add, taint_pkg::op_mul};
        for (int k = 0; k < 5; k++) begin
            rand_word(x);
            rand_word(y);
            rand_word(xt);
            rand_word(m);
            xt = xt & m;
            rand_word(yt);
            rand_word(m);
            yt = yt & m;
            set_op(ops[k], x, y, xt, yt, taint_pkg::addr_t'(k), 1'b0);
            tick();
        end
        in_valid = 1'b0;
        tick();
        for (int k = 0; k < 5; k++) begin
            read_back("logic arith", taint_pkg::addr_t'(k), 1'b0);
        end
    endtask

    task automatic test_cmp_shift_red();
        op_case("eq masked", taint_pkg::op_eq, 16'h12F0, 16'h12A5, 16'h00FF, 16'h0000);
        check_word("eq masked taint", 16'h0001, rd_taint);
        op_case("eq clean", taint_pkg::op_eq, 16'h1234, 16'h1234, 16'h0000, 16'h0000);
        op_case("eq pinned", taint_pkg::op_eq, 16'h1234, 16'h5234, 16'h000F, 16'h0000);
        op_case("shl tainted amount", taint_pkg::op_shl, 16'h00F1, 16'h0003, 16'h0, 16'h0001);
        check_word("shl tainted amount taint", '1, rd_taint);
        op_case("shl clean", taint_pkg::op_shl, 16'h00F1, 16'h0004, 16'h0011, 16'h0000);
        op_case("shr clean", taint_pkg::op_shr, 16'hF000, 16'h0025, 16'h8100, 16'h0000);
        op_case("shr tainted amount", taint_pkg::op_shr, 16'h8000, 16'h0002, 16'h0, 16'h0100);
        op_case("red_or open", taint_pkg::op_red_or, 16'h0000, 16'h0, 16'h0100, 16'h0);
        op_case("red_or pinned", taint_pkg::op_red_or, 16'h0010, 16'h0, 16'h0100, 16'h0);
        op_case("red_and open", taint_pkg::op_red_and, 16'hFEFF, 16'h0, 16'h0100, 16'h0);
        op_case("red_and pinned", taint_pkg::op_red_and, 16'hFEFF, 16'h0, 16'h0001, 16'h0);
        op_case("red_xor tainted", taint_pkg::op_red_xor, 16'h1234, 16'h0, 16'h8000, 16'h0);
        op_case("red_xor clean", taint_pkg::op_red_xor, 16'h1234, 16'h0, 16'h0000, 16'h0);
    endtask

    task automatic test_poison();
        write_op(taint_pkg::op_or, 16'h00F0, 16'h0F00, '0, '0, 4'd7, 1'b1);
        read_back("poison wr", 4'd7, 1'b0);
        check_word("poison wr taint", '1, rd_taint);
        write_op(taint_pkg::op_xor, 16'h0005, 16'h0003, '0, '0, 4'd8, 1'b0);
        read_back("poison rd", 4'd8, 1'b1);
        check_word("poison rd data", 16'h0006, rd_data);
        check_word("poison rd taint", '1, rd_taint);
    endtask

    task automatic test_enable_taint();
        write_op(taint_pkg::op_add, 16'h0100, 16'h0023, '0, '0, 4'd9, 1'b0);
        // enable low but itself tainted
        set_op(taint_pkg::op_add, 16'h0100, 16'h0042, '0, '0, 4'd9, 1'b0);
        in_valid = 1'b0;
        in_valid_taint = 1'b1;
        tick();
        in_valid_taint = 1'b0;
        check_word("held taint", 16'h0061, dut0.wr_bus.data_taint);
        tick();
        read_back("not written", 4'd9, 1'b0);
        check_word("not written data", 16'h0123, rd_data);
        check_word("not written taint", '0, rd_taint);
        set_op(taint_pkg::op_xor, 16'h0F0F, 16'h00FF, '0, '0, 4'd9, 1'b0);
        in_valid_taint = 1'b1;
        tick();
        in_valid = 1'b0;
        in_valid_taint = 1'b0;
        tick();
        read_back("enable write", 4'd9, 1'b0);
        check_word("enable write taint", '1, rd_taint);
    endtask

    task automatic test_count();
        taint_pkg::count_t prev;
        prev = count_tainted();
        check_count("count start", prev, taint_count);
        write_op(taint_pkg::op_and, 16'hFFFF, 16'h00FF, 16'h0001, '0, 4'd12, 1'b0);
        tick();
        check_count("count up", prev + 1'b1, taint_count);
        // clean overwrite of a poisoned word
        write_op(taint_pkg::op_or, 16'h0001, 16'h0002, '0, '0, 4'd9, 1'b0);
        tick();
        check_count("count down", prev, taint_count);
        check_count("count model", m_count, taint_count);
    endtask

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial begin
        in_valid = 1'b0;
        in_valid_taint = 1'b0;
        op = taint_pkg::op_and;
        a = '0;
        b = '0;
        a_taint = '0;
        b_taint = '0;
        wr_addr = '0;
        wr_addr_taint = 1'b0;
        rd_en = 1'b0;
        rd_addr = '0;
        rd_addr_taint = 1'b0;
        lfsr = 32'h0691_3369;
        m_valid = 1'b0;
        m_en_taint = 1'b0;
        m_addr_taint = 1'b0;
        m_data = '0;
        m_taint = '0;
        m_addr = '0;
        m_rd_data = '0;
        m_rd_taint = '0;
        m_count = '0;
        for (int i = 0; i < DEPTH; i++) begin
            m_mem_data[i] = '0;
            m_mem_taint[i] = '0;
        end
        @(negedge pos_arst);
        test_reset();
        test_logic_arith();
        test_cmp_shift_red();
        test_poison();
        test_enable_taint();
        test_count();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: sources.f
taint_pkg.sv
taint_bus_if.sv
taint_alu.sv
taint_stage.sv
taint_mem.sv
taint_core.sv
tb_clock.sv
taint_tb.sv
